// ==== hw/cpu_word_pkg.sv ====
`default_nettype none

package cpu_word_pkg;

	// Machine word of the minicomputer
	localparam int word_w = 16;
	localparam int word_msb = word_w - 1;

	typedef logic [word_msb:0] word_t;

	// User bits 9..15 of R0
	localparam int usr_w = 7;

	// R0 in architecture order, bit 0 sits at the MSB end
	typedef struct packed {
		// Zero
		logic z;
		// Minus, sign of the last result
		logic m;
		// Sticky overflow
		logic v;
		// Carry out
		logic c;
		// Compare less, equal, greater
		logic l;
		logic e;
		logic g;
		// Bits shifted out left and right
		logic y;
		logic x;
		logic [usr_w-1:0] usr;
	} r0_flags_t;

	// Same sixteen bits, raw or by flag name
	typedef union packed {
		word_t w;
		r0_flags_t f;
	} r0_word_t;

	// Host register map
	typedef logic [2:0] addr_t;

	localparam addr_t addr_a = 3'd0;
	localparam addr_t addr_b = 3'd1;
	localparam addr_t addr_cmd = 3'd2;
	localparam addr_t addr_r0 = 3'd3;
	localparam addr_t addr_res = 3'd4;

endpackage

`default_nettype wire

// ==== hw/cpu_op_pkg.sv ====
`default_nettype none

package cpu_op_pkg;

	// Operation codes, carried in the low bits of a command
	typedef enum logic [2:0] {
		add = 3'd0,
		sub = 3'd1,
		cmp = 3'd2,
		and_op = 3'd3,
		or_op = 3'd4,
		shl = 3'd5,
		shr = 3'd6,
		ldr0 = 3'd7
	} op_t;

	// Top bit of the opcode field in the command word
	localparam int cmd_op_hi = 2;

	// Flag update strobes, named after the R0 control lines
	typedef struct packed {
		logic ust_z;
		logic ust_mc;
		logic ust_v;
		logic cleg;
		logic ust_y;
		logic ust_x;
		logic load_all;
	} upd_t;

endpackage

`default_nettype wire

// ==== hw/op_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface op_if;

	// One decoded operation per valid cycle
	logic valid;
	cpu_op_pkg::op_t op;
	cpu_word_pkg::word_t a;
	// B as the adder sees it
	cpu_word_pkg::word_t b_eff;
	logic carry_in;
	cpu_op_pkg::upd_t upd;

	modport decode (
		output valid, op, a, b_eff, carry_in, upd
	);

	modport alu (
		input valid, op, a, b_eff, carry_in, upd
	);

endinterface

`default_nettype wire

// ==== hw/flag_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface flag_if;

	logic valid;
	cpu_op_pkg::upd_t upd;
	// Result zero and sign
	logic zs;
	logic s_1;
	// Signed overflow
	logic s0;
	logic carry;
	// Compare outcome
	logic vl;
	logic ve;
	logic vg;
	// Shifted-out bits
	logic exy;
	logic exx;
	// Word for a whole R0 load
	cpu_word_pkg::word_t ldw;

	modport alu (
		output valid, upd, zs, s_1, s0, carry, vl, ve, vg, exy, exx, ldw
	);

	modport flags (
		input valid, upd, zs, s_1, s0, carry, vl, ve, vg, exy, exx, ldw
	);

endinterface

`default_nettype wire

// ==== hw/bus_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_slave (
	input wire logic lrp,
	input wire logic zer_,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire cpu_word_pkg::addr_t adr,
	input wire cpu_word_pkg::word_t dat_w,
	output cpu_word_pkg::word_t dat_r,
	output logic ack,
	input wire cpu_word_pkg::word_t r0,
	input wire cpu_word_pkg::word_t result,
	output logic cmd_valid,
	output cpu_op_pkg::op_t cmd_op,
	output cpu_word_pkg::word_t a,
	output cpu_word_pkg::word_t b
);

	logic req;
	logic wr_cmd;

	// New request only while ack is low, so each transfer takes two cycles
	assign req = cyc && stb && !ack;
	assign wr_cmd = req && we && (adr == cpu_word_pkg::addr_cmd);

	// Ack, operand stores and command pulse all land on the same edge
	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			ack <= 1'b0;
			cmd_valid <= 1'b0;
			a <= '0;
			b <= '0;
		end else begin
			ack <= req;
			// Pulse lines up with the ack cycle
			cmd_valid <= wr_cmd;
			if (req && we) begin
				case (adr)
					cpu_word_pkg::addr_a: a <= dat_w;
					cpu_word_pkg::addr_b: b <= dat_w;
					default: ;
				endcase
			end
		end
	end

	// Opcode only matters while cmd_valid is high
	always_ff @(posedge lrp) begin
		if (wr_cmd)
			cmd_op <= cpu_op_pkg::op_t'(dat_w[cpu_op_pkg::cmd_op_hi:0]);
	end

	// Read mux, holes in the map read as zero
	always_comb begin
		case (adr)
			cpu_word_pkg::addr_a: dat_r = a;
			cpu_word_pkg::addr_b: dat_r = b;
			cpu_word_pkg::addr_r0: dat_r = r0;
			cpu_word_pkg::addr_res: dat_r = result;
			default: dat_r = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module op_decode (
	input wire logic lrp,
	input wire logic zer_,
	input wire logic cmd_valid,
	input wire cpu_op_pkg::op_t cmd_op,
	input wire cpu_word_pkg::word_t a,
	input wire cpu_word_pkg::word_t b,
	op_if.decode o
);

	cpu_op_pkg::upd_t upd_d;
	logic subtract;

	// Sub and cmp run through the adder as a + ~b + 1
	assign subtract = (cmd_op == cpu_op_pkg::sub) || (cmd_op == cpu_op_pkg::cmp);

	// Which R0 groups each operation touches
	always_comb begin
		upd_d = '0;
		case (cmd_op)
			cpu_op_pkg::add, cpu_op_pkg::sub: begin
				upd_d.ust_z = 1'b1;
				upd_d.ust_mc = 1'b1;
				upd_d.ust_v = 1'b1;
			end
			// Compare leaves everything but L, E, G alone
			cpu_op_pkg::cmp: upd_d.cleg = 1'b1;
			cpu_op_pkg::and_op, cpu_op_pkg::or_op: begin
				upd_d.ust_z = 1'b1;
				upd_d.ust_mc = 1'b1;
			end
			cpu_op_pkg::shl: begin
				upd_d.ust_z = 1'b1;
				upd_d.ust_mc = 1'b1;
				upd_d.ust_y = 1'b1;
			end
			cpu_op_pkg::shr: begin
				upd_d.ust_z = 1'b1;
				upd_d.ust_mc = 1'b1;
				upd_d.ust_x = 1'b1;
			end
			cpu_op_pkg::ldr0: upd_d.load_all = 1'b1;
			default: ;
		endcase
	end

	// Control side of the stage
	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			o.valid <= 1'b0;
			o.upd <= '0;
		end else begin
			o.valid <= cmd_valid;
			o.upd <= upd_d;
		end
	end

	// Operands follow along, qualified by valid downstream
	always_ff @(posedge lrp) begin
		o.op <= cmd_op;
		o.a <= a;
		o.b_eff <= subtract ? ~b : b;
		o.carry_in <= subtract;
	end

endmodule

`default_nettype wire

// ==== hw/alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_stage (
	input wire logic lrp,
	input wire logic zer_,
	op_if.alu i,
	flag_if.alu o,
	output cpu_word_pkg::word_t result
);

	localparam int msb = cpu_word_pkg::word_msb;

	logic [msb+1:0] sum;
	cpu_word_pkg::word_t res_d;
	logic ovf;
	logic lt;
	logic diff_zero;
	logic carry_d;
	logic s0_d;
	logic exy_d;
	logic exx_d;

	always_comb begin
		// One adder for add, sub and cmp
		sum = {1'b0, i.a} + {1'b0, i.b_eff} + {{msb+1{1'b0}}, i.carry_in};
		// Same-sign inputs giving a different-sign sum
		ovf = (i.a[msb] == i.b_eff[msb]) && (sum[msb] != i.a[msb]);
		// Signed less-than from the difference sign corrected by overflow
		lt = sum[msb] ^ ovf;
		diff_zero = (sum[msb:0] == '0);
		res_d = sum[msb:0];
		carry_d = 1'b0;
		s0_d = 1'b0;
		exy_d = 1'b0;
		exx_d = 1'b0;
		case (i.op)
			cpu_op_pkg::add, cpu_op_pkg::sub, cpu_op_pkg::cmp: begin
				carry_d = sum[msb+1];
				s0_d = ovf;
			end
			// Logic ops leave C cleared
			cpu_op_pkg::and_op: res_d = i.a & i.b_eff;
			cpu_op_pkg::or_op: res_d = i.a | i.b_eff;
			cpu_op_pkg::shl: begin
				res_d = {i.a[msb-1:0], 1'b0};
				exy_d = i.a[msb];
			end
			cpu_op_pkg::shr: begin
				res_d = {1'b0, i.a[msb:1]};
				exx_d = i.a[0];
			end
			// Loaded word shows up as the result too
			cpu_op_pkg::ldr0: res_d = i.b_eff;
			default: ;
		endcase
	end

	// Control side and the host-visible result
	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			o.valid <= 1'b0;
			o.upd <= '0;
			result <= '0;
		end else begin
			o.valid <= i.valid;
			o.upd <= i.upd;
			if (i.valid)
				result <= res_d;
		end
	end

	// Condition lines for the flag register
	always_ff @(posedge lrp) begin
		o.zs <= (res_d == '0);
		o.s_1 <= res_d[msb];
		o.s0 <= s0_d;
		o.carry <= carry_d;
		o.vl <= lt;
		o.ve <= diff_zero;
		o.vg <= !lt && !diff_zero;
		o.exy <= exy_d;
		o.exx <= exx_d;
		// B passes untouched for ldr0
		o.ldw <= i.b_eff;
	end

endmodule

`default_nettype wire

// ==== hw/flag_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_reg (
	input wire logic lrp,
	input wire logic zer_,
	flag_if.flags i,
	output cpu_word_pkg::word_t r0
);

	cpu_word_pkg::r0_word_t r0_q;
	logic load;

	assign load = i.valid && i.upd.load_all;
	assign r0 = r0_q.w;

	always_ff @(posedge lrp or negedge zer_) begin
		if (!zer_) begin
			r0_q <= '0;
		end else if (load) begin
			// Whole word, user bits and V included
			r0_q.w <= i.ldw;
		end else if (i.valid) begin
			if (i.upd.ust_z)
				r0_q.f.z <= i.zs;
			// M and C share one strobe
			if (i.upd.ust_mc) begin
				r0_q.f.m <= i.s_1;
				r0_q.f.c <= i.carry;
			end
			// V only accumulates
			if (i.upd.ust_v)
				r0_q.f.v <= r0_q.f.v | i.s0;
			if (i.upd.cleg) begin
				r0_q.f.l <= i.vl;
				r0_q.f.e <= i.ve;
				r0_q.f.g <= i.vg;
			end
			if (i.upd.ust_y)
				r0_q.f.y <= i.exy;
			if (i.upd.ust_x)
				r0_q.f.x <= i.exx;
		end
	end

	// Sticky overflow drops only through a whole load
	assert property (@(posedge lrp) disable iff (!zer_)
		$fell(r0_q.f.v) |-> $past(load))
		else $error("V cleared without ldr0");

	// Compare outcome from the ALU is one-hot around E
	assert property (@(posedge lrp) disable iff (!zer_)
		(i.valid && i.upd.cleg && !i.upd.load_all) |=>
			!(r0_q.f.e && r0_q.f.l) && !(r0_q.f.e && r0_q.f.g))
		else $error("E set together with L or G");

	// Arithmetic never touches the user field
	assert property (@(posedge lrp) disable iff (!zer_)
		!$stable(r0_q.f.usr) |-> $past(load))
		else $error("user bits changed without ldr0");

endmodule

`default_nettype wire

// ==== hw/flag_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_unit (
	input wire logic lrp,
	input wire logic zer_,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [2:0] adr,
	input wire logic [15:0] dat_w,
	output logic [15:0] dat_r,
	output logic ack
);

	cpu_word_pkg::word_t r0;
	cpu_word_pkg::word_t result;
	cpu_word_pkg::word_t a;
	cpu_word_pkg::word_t b;
	logic cmd_valid;
	cpu_op_pkg::op_t cmd_op;

	// Decode to ALU, then ALU to R0
	op_if u_op ();
	flag_if u_flag ();

	bus_slave i_bus (
		.lrp(lrp),
		.zer_(zer_),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack),
		.r0(r0),
		.result(result),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.a(a),
		.b(b)
	);

	op_decode i_dec (
		.lrp(lrp),
		.zer_(zer_),
		.cmd_valid(cmd_valid),
		.cmd_op(cmd_op),
		.a(a),
		.b(b),
		.o(u_op.decode)
	);

	alu_stage i_alu (
		.lrp(lrp),
		.zer_(zer_),
		.i(u_op.alu),
		.o(u_flag.alu),
		.result(result)
	);

	// R0 settles three edges after the command ack
	flag_reg i_r0 (
		.lrp(lrp),
		.zer_(zer_),
		.i(u_flag.flags),
		.r0(r0)
	);

endmodule

`default_nettype wire

// ==== tests/flag_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_unit_tb;

	// R0 bit positions in the bus word, Z at the MSB end
	localparam int bit_z = 15;
	localparam int bit_m = 14;
	localparam int bit_v = 13;
	localparam int bit_c = 12;
	localparam int bit_l = 11;
	localparam int bit_e = 10;
	localparam int bit_g = 9;
	localparam int bit_y = 8;
	localparam int bit_x = 7;

	localparam int n_rand = 200;
	// Directed and burst operations on top of the random ones
	localparam int n_fixed = 40;
	// Three writes, the pipeline wait and two reads, rounded up
	localparam int cycles_per_op = 16;
	localparam int max_cycles = (n_rand + n_fixed) * cycles_per_op + 100;

	logic lrp;
	logic zer_;
	logic cyc;
	logic stb;
	logic we;
	logic [2:0] adr;
	logic [15:0] dat_w;
	logic [15:0] dat_r;
	logic ack;

	// Reference copy of R0 and the result register
	logic [15:0] exp_r0;
	logic [15:0] exp_res;

	// Read check armed by the bus read task
	logic chk_en;
	logic chk_leg;
	logic [15:0] chk_exp;
	string chk_what;

	int cycles;

	flag_unit i_dut (
		.lrp(lrp),
		.zer_(zer_),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	always #50 lrp = ~lrp;

	// Run length guard
	always @(posedge lrp) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Regression failed");
			$fatal(1, "cycle limit reached");
		end
	end

	// Read data in the ack cycle against the model
	read_matches: assert property (@(posedge lrp) disable iff (!zer_)
		(chk_en && ack) |-> (dat_r == chk_exp))
		else begin
			$display("mismatch at %0t: %s read differs, expected %h", $time, chk_what, chk_exp);
			$display("Regression failed");
			$fatal(1, "read check");
		end

	// A compare leaves exactly one of L, E, G
	leg_onehot: assert property (@(posedge lrp) disable iff (!zer_)
		(chk_en && chk_leg && ack) |-> $onehot(dat_r[bit_l:bit_g]))
		else begin
			$display("mismatch at %0t: L, E and G not exactly one set after cmp", $time);
			$display("Regression failed");
			$fatal(1, "compare flags");
		end

	// No ack without a bus cycle
	ack_idle: assert property (@(posedge lrp) disable iff (!zer_)
		!(cyc && stb) |=> !ack)
		else begin
			$display("mismatch at %0t: ack rose with no bus cycle", $time);
			$display("Regression failed");
			$fatal(1, "ack without cycle");
		end

	// Ack low and operand A zero coming out of reset
	reset_state: assert property (@(posedge lrp)
		$rose(zer_) |-> (!ack && dat_r == 16'h0000))
		else begin
			$display("mismatch at %0t: bus port not idle after reset", $time);
			$display("Regression failed");
			$fatal(1, "reset state");
		end

	// Sequential R0 and result rules for one operation
	task automatic apply_model(input cpu_op_pkg::op_t op, input logic [15:0] a,
			input logic [15:0] b);
		logic [16:0] wide;
		logic [15:0] res;
		int sa;
		int sb;
		int sr;
		sa = int'($signed(a));
		sb = int'($signed(b));
		res = '0;
		case (op)
			cpu_op_pkg::add: begin
				wide = {1'b0, a} + {1'b0, b};
				res = wide[15:0];
				sr = sa + sb;
				exp_r0[bit_c] = wide[16];
				exp_r0[bit_v] = exp_r0[bit_v] | (sr > 32767) | (sr < -32768);
			end
			cpu_op_pkg::sub: begin
				res = a - b;
				sr = sa - sb;
				// Carry means no borrow
				exp_r0[bit_c] = (a >= b);
				exp_r0[bit_v] = exp_r0[bit_v] | (sr > 32767) | (sr < -32768);
			end
			cpu_op_pkg::cmp: begin
				res = a - b;
				exp_r0[bit_l] = (sa < sb);
				exp_r0[bit_e] = (sa == sb);
				exp_r0[bit_g] = (sa > sb);
			end
			cpu_op_pkg::and_op: begin
				res = a & b;
				exp_r0[bit_c] = 1'b0;
			end
			cpu_op_pkg::or_op: begin
				res = a | b;
				exp_r0[bit_c] = 1'b0;
			end
			cpu_op_pkg::shl: begin
				res = a << 1;
				exp_r0[bit_c] = 1'b0;
				exp_r0[bit_y] = a[15];
			end
			cpu_op_pkg::shr: begin
				res = a >> 1;
				exp_r0[bit_c] = 1'b0;
				exp_r0[bit_x] = a[0];
			end
			default: begin
				// Whole-word load
				res = b;
				exp_r0 = b;
			end
		endcase
		// Z and M follow every op except cmp and ldr0
		if (op != cpu_op_pkg::cmp && op != cpu_op_pkg::ldr0) begin
			exp_r0[bit_z] = (res == 16'h0000);
			exp_r0[bit_m] = res[15];
		end
		exp_res = res;
	endtask

	// One classic write, two cycles with the idle one
	task automatic bus_write(input logic [2:0] addr, input logic [15:0] data);
		@(negedge lrp);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = addr;
		dat_w = data;
		@(negedge lrp);
		while (!ack)
			@(negedge lrp);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	// One classic read, checked by the assertions during ack
	task automatic check_read(input logic [2:0] addr, input logic [15:0] expected,
			input string what, input logic leg);
		@(negedge lrp);
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = addr;
		chk_exp = expected;
		chk_what = what;
		chk_leg = leg;
		chk_en = 1'b1;
		@(negedge lrp);
		while (!ack)
			@(negedge lrp);
		cyc = 1'b0;
		stb = 1'b0;
		// Stay armed over the edge that samples the ack cycle
		@(negedge lrp);
		chk_en = 1'b0;
		chk_leg = 1'b0;
	endtask

	// Command alone, a and b are the operands already held in A and B
	task automatic issue_cmd(input cpu_op_pkg::op_t op, input logic [15:0] a,
			input logic [15:0] b);
		// Upper command bits are don't-care
		bus_write(cpu_word_pkg::addr_cmd, {13'($urandom), op});
		apply_model(op, a, b);
	endtask

	// Operands and command, no wait for the pipeline
	task automatic issue_op(input cpu_op_pkg::op_t op, input logic [15:0] a,
			input logic [15:0] b);
		bus_write(cpu_word_pkg::addr_a, a);
		bus_write(cpu_word_pkg::addr_b, b);
		issue_cmd(op, a, b);
	endtask

	// R0 settles three cycles after the command ack
	task automatic check_state(input logic leg);
		repeat (3)
			@(negedge lrp);
		check_read(cpu_word_pkg::addr_r0, exp_r0, "R0", leg);
		check_read(cpu_word_pkg::addr_res, exp_res, "result", 1'b0);
	endtask

	task automatic run_op(input cpu_op_pkg::op_t op, input logic [15:0] a,
			input logic [15:0] b);
		issue_op(op, a, b);
		check_state(op == cpu_op_pkg::cmp);
	endtask

	initial begin
		cpu_op_pkg::op_t op;
		logic [15:0] a;
		logic [15:0] b;
		void'($urandom(52693));
		lrp = 1'b0;
		zer_ = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		chk_en = 1'b0;
		chk_leg = 1'b0;
		chk_exp = '0;
		chk_what = "";
		cycles = 0;
		exp_r0 = '0;
		exp_res = '0;
		repeat (3)
			@(posedge lrp);
		@(negedge lrp);
		zer_ = 1'b1;

		// Post-reset state, plus a hole in the map
		check_read(cpu_word_pkg::addr_r0, 16'h0000, "R0", 1'b0);
		check_read(cpu_word_pkg::addr_res, 16'h0000, "result", 1'b0);
		check_read(3'd5, 16'h0000, "unused address", 1'b0);

		// Overflow sets V, later clean adds keep it
		run_op(cpu_op_pkg::add, 16'h7fff, 16'h0001);
		run_op(cpu_op_pkg::add, 16'h0001, 16'h0001);
		run_op(cpu_op_pkg::sub, 16'h0000, 16'h0001);
		run_op(cpu_op_pkg::add, 16'hffff, 16'h0001);
		run_op(cpu_op_pkg::sub, 16'h8000, 16'h0001);

		// Equal, less and greater, signed
		run_op(cpu_op_pkg::cmp, 16'h0005, 16'h0005);
		run_op(cpu_op_pkg::cmp, 16'hffff, 16'h0001);
		run_op(cpu_op_pkg::cmp, 16'h0001, 16'hffff);

		run_op(cpu_op_pkg::shl, 16'h8001, 16'h1234);
		run_op(cpu_op_pkg::shr, 16'h0003, 16'h4321);

		// Whole load with user bits, then logic ops
		run_op(cpu_op_pkg::ldr0, 16'h0000, 16'ha5c3);
		run_op(cpu_op_pkg::and_op, 16'hf0f0, 16'h0f0f);
		run_op(cpu_op_pkg::or_op, 16'h8000, 16'h0001);
		run_op(cpu_op_pkg::ldr0, 16'h0000, 16'h0000);

		// Commands in flight together, each sent before the last one reaches R0
		issue_op(cpu_op_pkg::add, 16'h4000, 16'h4000);
		issue_cmd(cpu_op_pkg::cmp, 16'h4000, 16'h4000);
		issue_cmd(cpu_op_pkg::shl, 16'h4000, 16'h4000);
		issue_cmd(cpu_op_pkg::sub, 16'h4000, 16'h4000);
		check_state(1'b0);
		issue_op(cpu_op_pkg::cmp, 16'h0010, 16'h0020);
		issue_cmd(cpu_op_pkg::shr, 16'h0010, 16'h0020);
		issue_op(cpu_op_pkg::shl, 16'hc000, 16'h0000);
		issue_cmd(cpu_op_pkg::cmp, 16'hc000, 16'h0000);
		check_state(1'b1);

		for (int n = 0; n < n_rand; n++) begin
			op = cpu_op_pkg::op_t'(3'($urandom_range(0, 7)));
			a = 16'($urandom);
			// Equal operands now and then for E and Z
			b = ($urandom_range(0, 3) == 0) ? a : 16'($urandom);
			if ($urandom_range(0, 4) == 0)
				issue_op(op, a, b);
			else
				run_op(op, a, b);
		end
		check_state(1'b0);

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/cpu_word_pkg.sv
hw/cpu_op_pkg.sv
hw/op_if.sv
hw/flag_if.sv
hw/bus_slave.sv
hw/op_decode.sv
hw/alu_stage.sv
hw/flag_reg.sv
hw/flag_unit.sv
tests/flag_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module flag_unit_tb \
	-Mdir obj_dir -o flag_unit_sim &&
{ ./obj_dir/flag_unit_sim > sim.log 2>&1; cat sim.log; true; } &&
test -s sim.log &&
! grep -q "Regression failed" sim.log &&
grep -q "Regression passed" sim.log &&
echo "simulation OK" ||
{ echo "simulation FAILED, see sim.log"; exit 1; }
